//--- stepper_ctl.f
source/stepper_pkg.sv
source/spi_word_rx.sv
source/cmd_decode.sv
source/move_exec.sv
source/phase_driver.sv
source/stepper_top.sv
tb/stepper_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the stepper controller testbench with Verilator

set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=stepper_sim
LOG_FILE=sim.log

if ! verilator --binary --timing -Wno-fatal --top-module stepper_tb \
    -f stepper_ctl.f --Mdir "$BUILD_DIR" -o "$SIM_BIN"; then
  echo "Verilator build failed"
  exit 1
fi

"./$BUILD_DIR/$SIM_BIN" > "$LOG_FILE" 2>&1
run_status=$?
cat "$LOG_FILE"
if [ "$run_status" -ne 0 ]; then
  echo "Simulation exited with status $run_status"
  exit 1
fi

if grep -q "^TEST PASSED$" "$LOG_FILE"; then
  exit 0
fi
echo "Pass message not found in $LOG_FILE"
exit 1

//--- tb/stepper_tb.sv
`default_nettype none

module stepper_tb;
  import stepper_pkg::*;

  localparam int          HALF_CYC  = 4;    // SCK half period in CLK cycles
  localparam int          WORD_CYC  = 560;  // One SPI word with CS gaps
  localparam int          N_WORDS   = 64;   // Upper bound on words sent
  localparam int          MAX_DUR   = 47;
  localparam int          MAX_DIV   = 6;
  localparam int          MOVE_CYC  = 200 + 75 + 4000 + 10 * MAX_DUR * MAX_DIV;
  localparam int          LIMIT_CYC = N_WORDS * WORD_CYC + MOVE_CYC + 2000;
  localparam logic [31:0] SEED      = 32'h8b06_4843;

  logic CLK, arst_n, sck, cs_n, copi;
  logic cipo, phase_a1, phase_a2, phase_b1, phase_b2, step, dir, busy;

  int unsigned     cur_div    = 40;  // Divisor of the next move
  logic            exp_dir    = 1'b0;
  logic            exp_half   = 1'b0;
  logic [2:0]      exp_idx    = 3'd0;  // Model phase index
  longint unsigned prev_dur   = 0;     // Expected reply values
  longint unsigned prev_steps = 0;
  longint unsigned move_steps = 0;     // Monitor counts, per move
  longint unsigned busy_len   = 0;
  longint unsigned cyc        = 0;
  longint unsigned last_step  = 0;
  logic            have_last  = 1'b0;
  int              err_cnt    = 0;
  int unsigned     rnd;

  stepper_top stepper_top_inst (
    .CLK(CLK), .arst_n(arst_n), .sck(sck), .cs_n(cs_n), .copi(copi), .cipo(cipo),
    .phase_a1(phase_a1), .phase_a2(phase_a2), .phase_b1(phase_b1), .phase_b2(phase_b2),
    .step(step), .dir(dir), .busy(busy)
  );

  always #5 CLK = ~CLK;

  task automatic check_val(input string name, input logic [63:0] got,
                           input logic [63:0] expected);
    if (got !== expected) begin
      err_cnt++;
      $display("error: time %0t, signal %s, got %0h, expected %0h",
               $time, name, got, expected);
      $display("TEST FAILED");
      $fatal(1);
    end
  endtask

  // Coil pattern {a1, a2, b1, b2} of each table state
  function automatic logic [3:0] phase_bits(input logic [2:0] idx);
    case (idx)
      3'd0:    return 4'b1000;  // A+
      3'd1:    return 4'b1010;  // A+ B+
      3'd2:    return 4'b0010;  // B+
      3'd3:    return 4'b0110;  // A- B+
      3'd4:    return 4'b0100;  // A-
      3'd5:    return 4'b0101;  // A- B-
      3'd6:    return 4'b0001;  // B-
      default: return 4'b1001;  // A+ B-
    endcase
  endfunction

  function automatic logic [2:0] next_index(input logic [2:0] idx, input logic fwd,
                                            input logic half);
    logic [2:0] start;
    start = half ? idx : (idx & 3'b110);  // Full steps round odd down
    if (half) begin
      return fwd ? start + 3'd1 : start - 3'd1;
    end
    return fwd ? start + 3'd2 : start - 3'd2;
  endfunction

  // Accumulator rule, steps of one move
  function automatic longint unsigned model_move(input longint unsigned dur,
                                                 input longint inc, input longint inc_inc);
    longint          acc;
    longint          rate;
    longint unsigned steps;
    longint unsigned k;
    acc   = 0;
    rate  = inc;
    steps = 0;
    for (k = 0; k < dur; k++) begin
      acc = acc + rate;
      if (acc > 0) begin
        steps++;
        acc = acc - longint'(STEP_THRESHOLD);
      end
      rate = rate + inc_inc;
    end
    return steps;
  endfunction

  // Mode 0 transfer, MSB first, CIPO read just before each SCK rise
  task automatic spi_xfer(input logic [63:0] tx, output logic [63:0] rx);
    @(posedge CLK);
    cs_n <= 1'b0;
    repeat (8) @(posedge CLK);  // Reply load at CS fall
    for (int i = 63; i >= 0; i--) begin
      sck  <= 1'b0;
      copi <= tx[i];
      repeat (HALF_CYC) @(posedge CLK);
      rx[i] = cipo;
      sck <= 1'b1;
      repeat (HALF_CYC) @(posedge CLK);
    end
    sck <= 1'b0;
    repeat (8) @(posedge CLK);  // Word strobe lands here
    cs_n <= 1'b1;
    repeat (8) @(posedge CLK);
  endtask

  // Settings word, reply outside a move is ticks_last
  task automatic send_cmd(input logic [7:0] cmd, input logic [23:0] arg);
    hdr_t        h;
    logic [63:0] rx;
    h.cmd = cmd;
    h.pad = '0;
    h.arg = arg;
    spi_xfer(h, rx);
    check_val("cipo ticks_last", rx, prev_dur);
  endtask

  task automatic set_divisor(input int unsigned d);
    send_cmd(CMD_DIVISOR, 24'(d));
    cur_div = d;
  endtask

  task automatic set_microstep(input logic [2:0] code);
    send_cmd(CMD_MICROSTEP, {21'd0, code});
    if (code <= 3'd1) begin
      exp_half = code[0];  // Other codes are rejected
    end
  endtask

  task automatic send_move(input logic d, input longint unsigned dur, input longint inc,
                           input longint inc_inc, input logic check_reply);
    hdr_t        h;
    logic [63:0] rx;
    h.cmd   = CMD_MOVE;
    h.pad   = '0;
    h.arg   = {23'd0, d};
    exp_dir = d;
    spi_xfer(h, rx);
    if (check_reply) check_val("cipo ticks_last", rx, prev_dur);
    spi_xfer(64'(dur), rx);
    if (check_reply) check_val("cipo steps_last", rx, prev_steps);
    spi_xfer(64'(inc), rx);
    spi_xfer(64'(inc_inc), rx);
  endtask

  // Short moves may already be over here, busy_len covers the rise
  task automatic finish_move(input longint unsigned dur, input longint unsigned exp_steps);
    @(negedge CLK);
    while (busy) @(negedge CLK);
    repeat (4) @(negedge CLK);  // Last step trails busy by one cycle
    check_val("busy cycles", busy_len, dur * cur_div);
    check_val("step count", move_steps, exp_steps);
    check_val("dir", 64'(dir), 64'(exp_dir));
    prev_dur   = dur;
    prev_steps = exp_steps;
  endtask

  task automatic run_move(input logic d, input longint unsigned dur, input longint inc,
                          input longint inc_inc);
    send_move(d, dur, inc, inc_inc, 1'b1);
    finish_move(dur, model_move(dur, inc, inc_inc));
  endtask

  // Rate stays in (0, threshold) so the accumulator never overflows
  task automatic gen_params(output logic d, output longint unsigned dur,
                            output longint inc, output longint inc_inc);
    logic [63:0] r;
    r       = {$urandom, $urandom};
    inc     = longint'((64'd1 << 61) | (r & 64'h1fff_ffff_ffff_ffff));
    r       = {$urandom, $urandom};
    inc_inc = longint'(r >> 8) - (64'sd1 <<< 55);  // Within +-2^55
    dur     = 64'(8 + ($urandom % 40));
    d       = 1'($urandom & 1);
  endtask

  task automatic run_random_move();
    logic            d;
    longint unsigned dur;
    longint          inc;
    longint          inc_inc;
    gen_params(d, dur, inc, inc_inc);
    run_move(d, dur, inc, inc_inc);
  endtask

  // Step, phase and busy monitor
  always @(negedge CLK) begin
    if (arst_n) begin
      cyc++;
      check_val("phases", 64'({phase_a1, phase_a2, phase_b1, phase_b2}),
                64'(phase_bits(exp_idx)));
      if (step) begin
        if (have_last) check_val("step interval mod divisor", (cyc - last_step) % cur_div, 0);
        last_step  = cyc;
        have_last  = 1'b1;
        move_steps = move_steps + 1;
        exp_idx    = next_index(exp_idx, exp_dir, exp_half);
      end
      if (stepper_top_inst.move_start) begin  // Start or restart
        move_steps = 0;
        busy_len   = 0;
        have_last  = 1'b0;
      end else if (busy) begin
        busy_len = busy_len + 1;
      end
    end
  end

  initial begin
    repeat (LIMIT_CYC) @(posedge CLK);
    $display("Watchdog timeout: run did not finish within %0d clock cycles", LIMIT_CYC);
    $display("TEST FAILED");
    $fatal(1);
  end

  initial begin
    logic            d;
    longint unsigned dur;
    longint          inc;
    longint          inc_inc;
    CLK    = 1'b0;
    arst_n = 1'b0;
    sck    = 1'b0;
    cs_n   = 1'b1;
    copi   = 1'b0;
    rnd    = $urandom(SEED);
    repeat (16) @(posedge CLK);
    arst_n <= 1'b1;
    @(negedge CLK);
    check_val("busy", 64'(busy), 64'd0);

    // Divisor and busy timing
    set_divisor(5);
    run_move(1'b1, 40, 64'sh3000_0000_0000_0000, 64'sd0);
    set_divisor(3);
    run_move(1'b0, 25, 64'sh2800_0000_0000_0000, 64'sh0010_0000_0000_0000);

    // Random moves, full steps
    repeat (4) begin
      set_divisor(1 + ($urandom % MAX_DIV));
      run_random_move();
    end

    // Code 3 rejected while in full steps, then half steps, back to full steps
    set_microstep(3'd3);
    run_random_move();
    set_microstep(3'd1);
    run_random_move();
    run_random_move();
    set_microstep(3'd0);
    run_random_move();

    // Long move replaced by a second one while busy
    set_divisor(4);
    send_move(1'b1, 1000, 64'sh2000_0000_0000_0000, 64'sd0, 1'b1);
    @(negedge CLK);
    check_val("busy", 64'(busy), 64'd1);
    gen_params(d, dur, inc, inc_inc);
    send_move(1'b1, dur, inc, inc_inc, 1'b0);
    finish_move(dur, model_move(dur, inc, inc_inc));
    run_random_move();  // Replies carry the restarted counts
    send_cmd(8'hff, 24'd0);  // Unknown code

    if (err_cnt == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- source/stepper_top.sv
`default_nettype none

module stepper_top (
  input  logic CLK,
  input  logic arst_n,
  input  logic sck,
  input  logic cs_n,
  input  logic copi,
  output logic cipo,
  output logic phase_a1,
  output logic phase_a2,
  output logic phase_b1,
  output logic phase_b2,
  output logic step,
  output logic dir,
  output logic busy
);
  import stepper_pkg::*;

  logic              word_valid;
  spi_word_u         rx_word;     // Last complete SPI word
  logic [WORD_W-1:0] reply_word;  // Next word back to the host
  move_status_t      status;
  move_params_t      params;
  logic              move_start;
  logic [DIV_W-1:0]  divisor;
  logic              half_step;

  // Host link
  spi_word_rx spi_word_rx_inst (
    .CLK        (CLK),
    .arst_n     (arst_n),
    .sck        (sck),
    .cs_n       (cs_n),
    .copi       (copi),
    .cipo       (cipo),
    .reply_word (reply_word),
    .word_valid (word_valid),
    .rx_word    (rx_word)
  );

  cmd_decode cmd_decode_inst (
    .CLK        (CLK),
    .arst_n     (arst_n),
    .word_valid (word_valid),
    .rx_word    (rx_word),
    .status     (status),
    .params     (params),
    .move_start (move_start),
    .divisor    (divisor),
    .half_step  (half_step),
    .reply_word (reply_word)
  );

  move_exec move_exec_inst (
    .CLK        (CLK),
    .arst_n     (arst_n),
    .move_start (move_start),
    .params     (params),
    .divisor    (divisor),
    .step       (step),
    .dir        (dir),
    .busy       (busy),
    .status     (status)
  );

  // Bridge sequencer follows the step pin
  phase_driver phase_driver_inst (
    .CLK       (CLK),
    .arst_n    (arst_n),
    .step      (step),
    .dir       (dir),
    .half_step (half_step),
    .phase_a1  (phase_a1),
    .phase_a2  (phase_a2),
    .phase_b1  (phase_b1),
    .phase_b2  (phase_b2)
  );

endmodule

`default_nettype wire

//--- source/phase_driver.sv
`default_nettype none

module phase_driver (
  input  logic CLK,
  input  logic arst_n,
  input  logic step,
  input  logic dir,
  input  logic half_step,
  output logic phase_a1,
  output logic phase_a2,
  output logic phase_b1,
  output logic phase_b2
);

  logic [2:0] idx;     // Position in eight-state table
  logic [2:0] base;    // Index before the move
  logic [2:0] stride;
  logic [3:0] coils;   // {a1, a2, b1, b2}

  // Full steps live on even states only
  assign base   = half_step ? idx : {idx[2:1], 1'b0};
  assign stride = half_step ? 3'd1 : 3'd2;

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      idx <= 3'd0;
    end else if (step) begin
      idx <= dir ? base + stride : base - stride;  // dir high is forward
    end
  end

  // "+" is the 1 pin of a winding, "-" the 2 pin
  always_comb begin
    case (idx)
      3'd0:    coils = 4'b1000;  // A+
      3'd1:    coils = 4'b1010;  // A+ B+
      3'd2:    coils = 4'b0010;  // B+
      3'd3:    coils = 4'b0110;  // A- B+
      3'd4:    coils = 4'b0100;  // A-
      3'd5:    coils = 4'b0101;  // A- B-
      3'd6:    coils = 4'b0001;  // B-
      default: coils = 4'b1001;  // A+ B-
    endcase
  end

  assign phase_a1 = coils[3];
  assign phase_a2 = coils[2];
  assign phase_b1 = coils[1];
  assign phase_b2 = coils[0];

endmodule

`default_nettype wire

//--- source/move_exec.sv
`default_nettype none

module move_exec (
  input  logic                          CLK,
  input  logic                          arst_n,
  input  logic                          move_start,
  input  stepper_pkg::move_params_t     params,
  input  logic [stepper_pkg::DIV_W-1:0] divisor,
  output logic                          step,
  output logic                          dir,
  output logic                          busy,
  output stepper_pkg::move_status_t     status
);
  import stepper_pkg::*;

  logic [DIV_W-1:0]         div_r;      // Divisor of the running move
  logic [DIV_W-1:0]         clk_cnt;    // Cycles into current tick
  logic [WORD_W-1:0]        dur_r;      // Duration in ticks
  logic signed [WORD_W-1:0] inc_inc_r;
  logic signed [WORD_W-1:0] rate;       // increment + k*inc_inc
  logic signed [WORD_W-1:0] acc;        // Substep accumulator
  logic signed [WORD_W-1:0] acc_sum;
  logic [WORD_W-1:0]        tick_cnt;
  logic [WORD_W-1:0]        step_cnt;
  logic                     tick;       // Last cycle of a tick period
  logic                     take_step;

  assign tick      = busy && (clk_cnt == div_r - 1'b1);
  assign acc_sum   = acc + rate;
  assign take_step = tick && (acc_sum > 0);  // Signed compare

  // Counters, accumulator and outputs
  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      busy     <= 1'b0;
      step     <= 1'b0;
      dir      <= 1'b0;
      clk_cnt  <= '0;
      tick_cnt <= '0;
      step_cnt <= '0;
      acc      <= '0;
    end else if (move_start) begin
      // Also a restart when already busy
      busy     <= (params.duration != '0);
      step     <= 1'b0;
      dir      <= params.dir;
      clk_cnt  <= '0;
      tick_cnt <= '0;
      step_cnt <= '0;
      acc      <= '0;
    end else begin
      step <= take_step;  // One cycle wide
      if (busy) begin
        clk_cnt <= tick ? '0 : clk_cnt + 1'b1;
      end
      if (tick) begin
        tick_cnt <= tick_cnt + 1'b1;
        busy     <= ((tick_cnt + 1'b1) != dur_r);  // Falls after last tick
        if (take_step) begin
          acc      <= acc_sum - STEP_THRESHOLD;
          step_cnt <= step_cnt + 1'b1;
        end else begin
          acc <= acc_sum;
        end
      end
    end
  end

  // Latched move data and the rate ramp
  always_ff @(posedge CLK) begin
    if (move_start) begin
      div_r     <= (divisor == '0) ? DIV_W'(1) : divisor;  // 0 runs as 1
      dur_r     <= params.duration;
      inc_inc_r <= params.inc_inc;
      rate      <= params.increment;
    end else if (tick) begin
      rate <= rate + inc_inc_r;  // Rate for the next tick
    end
  end

  // Counters hold after the move ends
  assign status.ticks_last = tick_cnt;
  assign status.steps_last = step_cnt;

endmodule

`default_nettype wire

//--- source/cmd_decode.sv
`default_nettype none

module cmd_decode (
  input  logic                           CLK,
  input  logic                           arst_n,
  input  logic                           word_valid,
  input  stepper_pkg::spi_word_u         rx_word,
  input  stepper_pkg::move_status_t      status,
  output stepper_pkg::move_params_t      params,
  output logic                           move_start,
  output logic [stepper_pkg::DIV_W-1:0]  divisor,
  output logic                           half_step,
  output logic [stepper_pkg::WORD_W-1:0] reply_word
);
  import stepper_pkg::*;

  logic       in_move;      // Collecting move data words
  logic [1:0] data_cnt;     // Data words taken so far
  logic       reply_steps;  // Next reply is steps_last
  hdr_t       hdr;          // Header view of the word

  assign hdr = rx_word.hdr;

  // Sequencing and settings registers
  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      in_move     <= 1'b0;
      data_cnt    <= '0;
      reply_steps <= 1'b0;
      move_start  <= 1'b0;
      divisor     <= DEFAULT_DIVISOR;
      half_step   <= 1'b0;  // Full steps
    end else begin
      move_start <= 1'b0;
      if (word_valid) begin
        if (!in_move) begin
          case (hdr.cmd)
            CMD_MOVE: begin
              in_move     <= 1'b1;
              data_cnt    <= '0;
              reply_steps <= 1'b1;  // Duration word carries steps_last
            end
            CMD_DIVISOR: begin
              divisor <= hdr.arg;
            end
            CMD_MICROSTEP: begin
              // Only codes 0 and 1 exist
              if (hdr.arg[2:1] == 2'b00) begin
                half_step <= hdr.arg[0];
              end
            end
            default: begin
              // Unknown command, no effect
            end
          endcase
        end else begin
          data_cnt <= data_cnt + 2'd1;
          if (data_cnt == 2'd2) begin  // inc_inc was the last one
            in_move     <= 1'b0;
            reply_steps <= 1'b0;  // Back to ticks_last
            move_start  <= 1'b1;
          end
        end
      end
    end
  end

  // Move parameters, raw view for data words
  always_ff @(posedge CLK) begin
    if (word_valid) begin
      if (!in_move) begin
        if (hdr.cmd == CMD_MOVE) begin
          params.dir <= hdr.arg[0];
        end
      end else begin
        case (data_cnt)
          2'd0:    params.duration  <= rx_word.raw;
          2'd1:    params.increment <= rx_word.raw;
          default: params.inc_inc   <= rx_word.raw;
        endcase
      end
    end
  end

  // Picked up by the SPI target at the next CS assertion
  assign reply_word = reply_steps ? status.steps_last : status.ticks_last;

endmodule

`default_nettype wire

//--- source/spi_word_rx.sv
`default_nettype none

module spi_word_rx (
  input  logic                           CLK,
  input  logic                           arst_n,
  input  logic                           sck,
  input  logic                           cs_n,
  input  logic                           copi,
  output logic                           cipo,
  input  logic [stepper_pkg::WORD_W-1:0] reply_word,
  output logic                           word_valid,
  output stepper_pkg::spi_word_u         rx_word
);
  import stepper_pkg::*;

  logic [1:0]        sck_sync;   // Two-flop synchronizers
  logic [1:0]        cs_sync;
  logic [1:0]        copi_sync;
  logic              sck_q;      // Synced SCK, one cycle late
  logic              cs_q;       // Synced CS, one cycle late
  logic              sck_rise;
  logic              sck_fall;
  logic              cs_active;
  logic              cs_fall;    // Start of a transaction
  logic [CNT_W-1:0]  bit_cnt;    // Bits taken in current word
  logic [WORD_W-1:0] rx_shift;   // Receive shifter, MSB first
  logic [WORD_W-1:0] tx_shift;   // Reply shifter

  // Input sync and edge history
  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      sck_sync  <= 2'b00;
      cs_sync   <= 2'b11;  // Deselected
      copi_sync <= 2'b00;
      sck_q     <= 1'b0;
      cs_q      <= 1'b1;
    end else begin
      sck_sync  <= {sck_sync[0], sck};
      cs_sync   <= {cs_sync[0], cs_n};
      copi_sync <= {copi_sync[0], copi};
      sck_q     <= sck_sync[1];
      cs_q      <= cs_sync[1];
    end
  end

  assign sck_rise  = sck_sync[1] & ~sck_q;
  assign sck_fall  = ~sck_sync[1] & sck_q;
  assign cs_active = ~cs_sync[1];
  assign cs_fall   = cs_active & cs_q;

  // Bit counting and end-of-word strobe
  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      bit_cnt    <= '0;
      word_valid <= 1'b0;
    end else begin
      word_valid <= 1'b0;
      if (!cs_active) begin
        bit_cnt <= '0;  // Partial word dropped
      end else if (sck_rise) begin
        bit_cnt    <= bit_cnt + 1'b1;  // Wraps to 0 after bit 63
        word_valid <= (bit_cnt == CNT_W'(WORD_W - 1));
      end
    end
  end

  // Mode 0, sample on rising edge
  always_ff @(posedge CLK) begin
    if (cs_active && sck_rise) begin
      rx_shift <= {rx_shift[WORD_W-2:0], copi_sync[1]};
    end
  end

  assign rx_word = rx_shift;  // Stable until next rising edge

  // Reply loaded at CS assertion, so MSB is out before first SCK rise
  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      tx_shift <= '0;
    end else if (cs_fall) begin
      tx_shift <= reply_word;
    end else if (cs_active && sck_fall) begin
      tx_shift <= {tx_shift[WORD_W-2:0], 1'b0};  // Next bit on falling edge
    end
  end

  assign cipo = tx_shift[WORD_W-1];

endmodule

`default_nettype wire

//--- source/stepper_pkg.sv
`default_nettype none

package stepper_pkg;

  // Host protocol widths
  localparam int WORD_W = 64;  // One SPI word
  localparam int DIV_W  = 24;  // Tick divisor
  localparam int CNT_W  = $clog2(WORD_W);  // Bit counter in the SPI target

  // Header command codes, top byte of a header word
  localparam logic [7:0] CMD_MOVE      = 8'h01;  // Header plus three data words
  localparam logic [7:0] CMD_DIVISOR   = 8'h03;
  localparam logic [7:0] CMD_MICROSTEP = 8'h04;

  // Taken off the accumulator per step
  localparam logic signed [WORD_W-1:0] STEP_THRESHOLD = 64'sh7fff_ffff_ffff_ff9b;

  localparam logic [DIV_W-1:0] DEFAULT_DIVISOR = 24'd40;  // Divisor out of reset

  // Header word layout
  typedef struct packed {
    logic [7:0]       cmd;  // Command code
    logic [31:0]      pad;  // Unused
    logic [DIV_W-1:0] arg;  // Bit 0 dir, bits 2:0 microstep code, or divisor
  } hdr_t;

  // Same 64 bits seen as header or as move data
  typedef union packed {
    logic [WORD_W-1:0] raw;
    hdr_t              hdr;
  } spi_word_u;

  // Move request handed to the engine
  typedef struct packed {
    logic                     dir;
    logic [WORD_W-1:0]        duration;   // Ticks
    logic signed [WORD_W-1:0] increment;  // Rate at tick 0
    logic signed [WORD_W-1:0] inc_inc;    // Rate change per tick
  } move_params_t;

  // Counts of the last (or running) move
  typedef struct packed {
    logic [WORD_W-1:0] ticks_last;
    logic [WORD_W-1:0] steps_last;
  } move_status_t;

endpackage

`default_nettype wire
